// File: vlog.f
common/valu_pkg.sv
verilog/simd_alu.sv
valu/valu_insn_queue.sv
valu/valu_issue.sv
valu/valu_result_queue.sv
verilog/valu_top.sv
verif/valu_chk.sv
verif/valu_scoreboard.sv
verif/valu_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the vector ALU testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f vlog.f \
  --top-module valu_tb \
  -o valu_sim

./obj_dir/valu_sim | tee sim.log

if grep -q "Something failed" sim.log; then
  echo "Simulation reported failure"
  exit 1
fi
echo "Simulation finished without failure"

// File: verif/valu_tb.sv
// Testbench top of the vector ALU lane; drives instructions and operand streams, reports the result
`timescale 1ns/1ps
`default_nettype none

module valu_tb import valu_pkg::*; ();

  logic                clk_i;
  logic                rst_ni;
  alu_insn_t           insn_i;
  logic                insn_valid_i;
  logic                insn_ready_o;
  elen_t               op_a_i;
  logic                op_a_valid_i;
  logic                op_a_ready_o;
  elen_t               op_b_i;
  logic                op_b_valid_i;
  logic                op_b_ready_o;
  strb_t               mask_i;
  logic                mask_valid_i;
  logic                mask_ready_o;
  result_t             res_o;
  logic                res_req_o;
  logic                res_gnt_i;
  logic [nr_vinsn-1:0] done_o;

  int sb_err;
  int sb_checked;
  int sb_pending;

  // Pending stimulus streams
  alu_insn_t ins_q [$];
  elen_t     a_q [$];
  elen_t     b_q [$];
  strb_t     m_q [$];

  logic [31:0] lfsr = 32'he3e4;
  int          next_id = 0;
  int          words_sent = 0;
  int          cycle_cnt = 0;
  int          tb_err = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          err_base = 0;
  bit          gap_en = 0;
  bit          ready_low_seen = 0;
  bit          take_ins;
  bit          take_a;
  bit          take_b;
  bit          take_m;

  valu_top dut (.*);

  valu_scoreboard i_scoreboard (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .res_i     (res_o),
    .res_req_i (res_req_o),
    .res_gnt_i (res_gnt_i),
    .done_i    (done_o),
    .err_cnt_o (sb_err),
    .checked_o (sb_checked),
    .pending_o (sb_pending)
  );

  initial clk_i = 1'b0;
  always #4 clk_i = ~clk_i;

  // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
  function automatic logic [63:0] next_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      v    = {v[62:0], lfsr[0]};
    end
    return v;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  // Expected word from the lane rules with lanes zero-extended then sign-fixed
  function automatic result_t expected_result(input alu_insn_t insn, input int widx,
                                              input elen_t a, input elen_t b, input strb_t m);
    int      w;
    int      epw;
    int      n;
    int      sh;
    elen_t   lm;
    elen_t   x;
    elen_t   y;
    elen_t   xs;
    elen_t   ys;
    elen_t   r;
    result_t e;
    w   = 8 << int'(insn.vsew);
    epw = 64 / w;
    lm  = (w == 64) ? '1 : ((64'd1 << w) - 64'd1);
    e.id    = insn.id;
    e.addr  = vaddr_t'(int'(insn.vd) * int'(vreg_words) + widx);
    e.wdata = '0;
    e.be    = '0;
    n = int'(insn.vl) - widx * epw;
    for (int i = 0; i < epw; i++) begin
      x  = insn.use_scalar ? (insn.scalar & lm) : ((a >> (i * w)) & lm);
      y  = (b >> (i * w)) & lm;
      xs = x[w-1] ? (x | ~lm) : x;
      ys = y[w-1] ? (y | ~lm) : y;
      sh = int'(y[5:0]) % w;
      case (insn.op)
        op_add:  r = x + y;
        op_sub:  r = x - y;
        op_rsub: r = y - x;
        op_and:  r = x & y;
        op_or:   r = x | y;
        op_xor:  r = x ^ y;
        op_minu: r = (x < y) ? x : y;
        op_max:  r = ($signed(xs) > $signed(ys)) ? x : y;
        op_sll:  r = x << sh;
        op_srl:  r = x >> sh;
        op_sra:  r = elen_t'($signed(xs) >>> sh);
        default: r = '0;
      endcase
      e.wdata = e.wdata | ((r & lm) << (i * w));
    end
    for (int k = 0; k < 8; k++) begin
      e.be[k] = ((k / (w / 8)) < n) && (insn.vm || m[k]);
    end
    return e;
  endfunction

  // Queue one instruction with its operands and expected words
  task automatic send(input int op, input int sew, input int vl, input bit vm, input bit scal);
    alu_insn_t insn;
    int        epw;
    int        nw;
    elen_t     a;
    elen_t     b;
    strb_t     m;
    epw = 8 >> sew;
    nw  = (vl + epw - 1) / epw;
    insn.id         = vid_t'(next_id);
    insn.op         = alu_op_e'(4'(op));
    insn.vsew       = vsew_e'(2'(sew));
    insn.vl         = vlen_t'(vl);
    insn.vd         = 5'(next_bits(5));
    insn.vm         = vm;
    insn.use_scalar = scal;
    insn.scalar     = next_bits(64);
    next_id++;
    for (int wi = 0; wi < nw; wi++) begin
      a = scal ? '0 : next_bits(64);
      b = next_bits(64);
      m = vm ? '1 : strb_t'(next_bits(8));
      if (!scal) a_q.push_back(a);
      b_q.push_back(b);
      if (!vm) m_q.push_back(m);
      i_scoreboard.add_expected(expected_result(insn, wi, a, b, m), wi == nw - 1);
    end
    words_sent += nw;
    ins_q.push_back(insn);
  endtask

  // Wait for the streams to drain and report one line
  task automatic end_test(input string name);
    int errs;
    while (ins_q.size() != 0 || a_q.size() != 0 || b_q.size() != 0 ||
           m_q.size() != 0 || sb_pending != 0) begin
      @(posedge clk_i);
    end
    repeat (4) @(posedge clk_i);
    errs = sb_err + tb_err - err_base;
    err_base = sb_err + tb_err;
    tests_run++;
    if (errs != 0) tests_failed++;
    $display("Test %0d %s: %s, %0d errors", tests_run, name, (errs == 0) ? "pass" : "FAIL", errs);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stream drivers
  //////////////////////////////////////////////////////////////////////

  // Handshakes are sampled mid-cycle
  always @(negedge clk_i) begin
    take_ins = insn_valid_i && insn_ready_o;
    take_a   = op_a_valid_i && op_a_ready_o;
    take_b   = op_b_valid_i && op_b_ready_o;
    take_m   = mask_valid_i && mask_ready_o;
    if (insn_valid_i && !insn_ready_o) ready_low_seen = 1'b1;
  end

  always @(posedge clk_i) begin
    logic [63:0] gap_bit;
    #1;
    if (rst_ni) begin
      if (take_ins) void'(ins_q.pop_front());
      if (take_a) void'(a_q.pop_front());
      if (take_b) void'(b_q.pop_front());
      if (take_m) void'(m_q.pop_front());
      gap_bit      = gap_en ? next_bits(1) : 64'd1;
      insn_valid_i = (ins_q.size() != 0);
      insn_i       = (ins_q.size() != 0) ? ins_q[0] : '0;
      op_a_valid_i = (a_q.size() != 0);
      op_a_i       = (a_q.size() != 0) ? a_q[0] : '0;
      op_b_valid_i = (b_q.size() != 0);
      op_b_i       = (b_q.size() != 0) ? b_q[0] : '0;
      mask_valid_i = (m_q.size() != 0);
      mask_i       = (m_q.size() != 0) ? m_q[0] : '0;
      res_gnt_i    = res_req_o && gap_bit[0];
    end
  end

  // Run limit grows with the queued words
  initial begin : watchdog
    while (cycle_cnt <= words_sent * 20 + 2000) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("Watchdog expired after %0d cycles, the DUT stopped making progress", cycle_cnt);
    $display("Something failed");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    rst_ni       = 1'b0;
    insn_i       = '0;
    insn_valid_i = 1'b0;
    op_a_i       = '0;
    op_a_valid_i = 1'b0;
    op_b_i       = '0;
    op_b_valid_i = 1'b0;
    mask_i       = '0;
    mask_valid_i = 1'b0;
    res_gnt_i    = 1'b0;
    repeat (16) @(posedge clk_i);
    #1 rst_ni = 1'b1;
    @(negedge clk_i);
    if (insn_ready_o !== 1'b1 || res_req_o !== 1'b0 || done_o !== '0 ||
        op_a_ready_o !== 1'b0 || op_b_ready_o !== 1'b0 || mask_ready_o !== 1'b0) begin
      $display("Error at %0t: outputs after reset are not idle", $time);
      tb_err++;
    end

    for (int op = 0; op < 3; op++) begin
      for (int s = 0; s < 4; s++) send(op, s, 2 * (8 >> s), 1'b1, 1'b0);
    end
    end_test("add sub rsub unmasked");

    for (int op = 3; op < 11; op++) send(op, op % 4, 2 * (8 >> (op % 4)), 1'b1, 1'b1);
    end_test("logic min max shifts with scalar");

    for (int s = 0; s < 4; s++) send(int'(next_bits(4)) % 11, s, (8 >> s) + 1, 1'b0, 1'b0);
    end_test("masked with partial last word");

    gap_en = 1'b1;
    for (int i = 0; i < 8; i++) begin
      send(int'(next_bits(4)) % 11, i % 4, 1 + int'(next_bits(5)) % (2 * (8 >> (i % 4))),
           next_bits(1) != 0, next_bits(1) != 0);
    end
    end_test("random grant gaps");

    ready_low_seen = 1'b0;
    for (int i = 0; i < 6; i++) send(0, 2, 16, 1'b1, 1'b0);
    // Fifth instruction waits on a full queue
    while (ins_q.size() != 0) begin
      @(posedge clk_i);
    end
    if (!ready_low_seen) begin
      $display("Error at %0t: insn_ready_o never dropped with a full instruction queue",
               $time);
      tb_err++;
    end
    end_test("back-to-back instructions");

    $display("Summary: %0d tests, %0d failed, %0d words checked, %0d errors",
             tests_run, tests_failed, sb_checked, sb_err + tb_err);
    if (sb_err + tb_err == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verif/valu_scoreboard.sv
// Scoreboard of the vector ALU testbench; compares granted result words and done pulses in order
`timescale 1ns/1ps
`default_nettype none

module valu_scoreboard import valu_pkg::*; (
  input  wire logic                clk_i,
  input  wire logic                rst_ni,
  input  wire result_t             res_i,
  input  wire logic                res_req_i,
  input  wire logic                res_gnt_i,
  input  wire logic [nr_vinsn-1:0] done_i,
  output int                       err_cnt_o,
  output int                       checked_o,
  output int                       pending_o
);

  // Expected words in issue order, with a flag on each instruction's last word
  result_t exp_q [$];
  bit      last_q [$];

  initial begin
    err_cnt_o = 0;
    checked_o = 0;
  end

  assign pending_o = exp_q.size();

  task automatic add_expected(input result_t r, input bit last);
    exp_q.push_back(r);
    last_q.push_back(last);
  endtask

  // Mid-cycle sampling, all outputs settled
  always @(negedge clk_i) begin
    result_t             e;
    bit                  last;
    elen_t               bm;
    logic [nr_vinsn-1:0] done_exp;
    if (rst_ni && res_req_i && res_gnt_i) begin
      if (exp_q.size() == 0) begin
        $display("Error at %0t: result word granted but none was expected", $time);
        err_cnt_o++;
      end else begin
        e    = exp_q.pop_front();
        last = last_q.pop_front();
        checked_o++;
        for (int k = 0; k < int'(strb_width); k++) begin
          bm[k*8 +: 8] = {8{e.be[k]}};
        end
        if (res_i.id !== e.id) begin
          $display("Fail at %0t: res_o.id got %h expected %h", $time, res_i.id, e.id);
          err_cnt_o++;
        end
        if (res_i.addr !== e.addr) begin
          $display("Fail at %0t: res_o.addr got %h expected %h", $time, res_i.addr, e.addr);
          err_cnt_o++;
        end
        if (res_i.be !== e.be) begin
          $display("Fail at %0t: res_o.be got %h expected %h", $time, res_i.be, e.be);
          err_cnt_o++;
        end
        // Only enabled bytes carry defined data
        if ((res_i.wdata & bm) !== (e.wdata & bm)) begin
          $display("Fail at %0t: res_o.wdata got %h expected %h", $time,
                   res_i.wdata & bm, e.wdata & bm);
          err_cnt_o++;
        end
        done_exp = last ? (nr_vinsn'(1) << e.id) : '0;
        if (done_i !== done_exp) begin
          $display("Fail at %0t: done_o got %b expected %b", $time, done_i, done_exp);
          err_cnt_o++;
        end
      end
    end else if (rst_ni && done_i != '0) begin
      $display("Fail at %0t: done_o got %b expected %b", $time, done_i, {nr_vinsn{1'b0}});
      err_cnt_o++;
    end
  end

endmodule

`default_nettype wire

// File: verif/valu_chk.sv
// Handshake assertions for the vector ALU lane, bound into valu_top by the bind at the end
`timescale 1ns/1ps
`default_nettype none

module valu_chk import valu_pkg::*; (
  input wire logic        clk_i,
  input wire logic        rst_ni,
  input wire issue_info_t issue_i,
  input wire logic        op_a_valid_i,
  input wire logic        op_a_ready_i,
  input wire logic        op_b_valid_i,
  input wire logic        op_b_ready_i,
  input wire logic        mask_valid_i,
  input wire logic        mask_ready_i,
  input wire result_t     res_i,
  input wire logic        res_req_i,
  input wire logic        res_gnt_i
);

  // Waiting request keeps its word
  a_req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    res_req_i && !res_gnt_i |=> res_req_i && $stable(res_i))
    else $error("result request dropped or changed before grant");

  // Scalar instructions never pull op_a
  a_op_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    op_a_ready_i |-> issue_i.valid && !issue_i.insn.use_scalar && op_a_valid_i)
    else $error("op_a ready for an instruction that does not use op_a");

  a_op_b: assert property (@(posedge clk_i) disable iff (!rst_ni)
    op_b_ready_i |-> issue_i.valid && op_b_valid_i)
    else $error("op_b ready without valid");

  // Unmasked instructions never pull the mask
  a_mask: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mask_ready_i |-> issue_i.valid && !issue_i.insn.vm && mask_valid_i)
    else $error("mask ready for an unmasked instruction");

endmodule

bind valu_top valu_chk i_valu_chk (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .issue_i      (issue_info),
  .op_a_valid_i (op_a_valid_i),
  .op_a_ready_i (op_a_ready_o),
  .op_b_valid_i (op_b_valid_i),
  .op_b_ready_i (op_b_ready_o),
  .mask_valid_i (mask_valid_i),
  .mask_ready_i (mask_ready_o),
  .res_i        (res_o),
  .res_req_i    (res_req_o),
  .res_gnt_i    (res_gnt_i)
);

`default_nettype wire

// File: verilog/valu_top.sv
// Top level of the vector ALU lane; wires instruction queue, issue stage, SIMD datapath and result queue
`timescale 1ns/1ps
`default_nettype none

module valu_top import valu_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,
  // Instructions
  input  alu_insn_t           insn_i,
  input  logic                insn_valid_i,
  output logic                insn_ready_o,
  // Operand streams
  input  elen_t               op_a_i,
  input  logic                op_a_valid_i,
  output logic                op_a_ready_o,
  input  elen_t               op_b_i,
  input  logic                op_b_valid_i,
  output logic                op_b_ready_o,
  input  strb_t               mask_i,
  input  logic                mask_valid_i,
  output logic                mask_ready_o,
  // Register-file write
  output result_t             res_o,
  output logic                res_req_o,
  input  logic                res_gnt_i,
  // Completion
  output logic [nr_vinsn-1:0] done_o
);

  issue_info_t issue_info;
  logic        issue_last;
  vlen_t       elem_issued;
  elen_t       alu_a;
  elen_t       alu_b;
  elen_t       alu_res;
  alu_op_e     alu_op;
  vsew_e       alu_vsew;
  logic        rq_full;
  logic        rq_push;
  result_t     rq_push_data;

  valu_insn_queue i_insn_queue (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .insn_i        (insn_i),
    .insn_valid_i  (insn_valid_i),
    .insn_ready_o  (insn_ready_o),
    .issue_o       (issue_info),
    .issue_last_i  (issue_last),
    .elem_issued_i (elem_issued),
    // Every grant retires one word
    .commit_i      (res_gnt_i),
    .done_o        (done_o)
  );

  valu_issue i_issue (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .issue_i       (issue_info),
    .issue_last_o  (issue_last),
    .elem_issued_o (elem_issued),
    .op_a_i        (op_a_i),
    .op_a_valid_i  (op_a_valid_i),
    .op_a_ready_o  (op_a_ready_o),
    .op_b_i        (op_b_i),
    .op_b_valid_i  (op_b_valid_i),
    .op_b_ready_o  (op_b_ready_o),
    .mask_i        (mask_i),
    .mask_valid_i  (mask_valid_i),
    .mask_ready_o  (mask_ready_o),
    .alu_a_o       (alu_a),
    .alu_b_o       (alu_b),
    .alu_op_o      (alu_op),
    .alu_vsew_o    (alu_vsew),
    .alu_res_i     (alu_res),
    .rq_full_i     (rq_full),
    .push_o        (rq_push),
    .push_data_o   (rq_push_data)
  );

  simd_alu i_simd_alu (
    .a_i      (alu_a),
    .b_i      (alu_b),
    .op_i     (alu_op),
    .vsew_i   (alu_vsew),
    .result_o (alu_res)
  );

  valu_result_queue i_result_queue (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .push_i      (rq_push),
    .push_data_i (rq_push_data),
    .full_o      (rq_full),
    .res_o       (res_o),
    .res_req_o   (res_req_o),
    .res_gnt_i   (res_gnt_i)
  );

endmodule

`default_nettype wire

// File: valu/valu_result_queue.sv
// Two-entry result FIFO of the vector ALU; its head requests the register-file write port
`timescale 1ns/1ps
`default_nettype none

module valu_result_queue import valu_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_ni,
  // Issue side
  input  logic    push_i,
  input  result_t push_data_i,
  output logic    full_o,
  // Register-file side
  output result_t res_o,
  output logic    res_req_o,
  input  logic    res_gnt_i
);

  // Result payload by slot
  result_t mem_q [result_queue_depth];

  logic [rq_idx_width-1:0] wr_pnt_q;
  logic [rq_idx_width-1:0] rd_pnt_q;
  logic [rq_idx_width:0]   cnt_q;
  logic                    pop;

  assign full_o    = (cnt_q == (rq_idx_width+1)'(result_queue_depth));
  assign res_req_o = (cnt_q != '0);
  assign res_o     = mem_q[rd_pnt_q];

  // Grant only counts against a pending request
  assign pop = res_gnt_i && res_req_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_pnt_q <= '0;
      rd_pnt_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_i) begin
        wr_pnt_q <= wr_pnt_q + 1'b1;
      end
      if (pop) begin
        rd_pnt_q <= rd_pnt_q + 1'b1;
      end
      // Occupancy
      case ({push_i, pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_pnt_q] <= push_data_i;
    end
  end

endmodule

`default_nettype wire

// File: valu/valu_issue.sv
// Issue stage of the vector ALU; gathers operands, builds byte enables and addresses, pushes results
`timescale 1ns/1ps
`default_nettype none

module valu_issue import valu_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  // Head of the instruction queue
  input  issue_info_t issue_i,
  output logic        issue_last_o,
  output vlen_t       elem_issued_o,
  // Operand streams
  input  elen_t       op_a_i,
  input  logic        op_a_valid_i,
  output logic        op_a_ready_o,
  input  elen_t       op_b_i,
  input  logic        op_b_valid_i,
  output logic        op_b_ready_o,
  input  strb_t       mask_i,
  input  logic        mask_valid_i,
  output logic        mask_ready_o,
  // SIMD datapath
  output elen_t       alu_a_o,
  output elen_t       alu_b_o,
  output alu_op_e     alu_op_o,
  output vsew_e       alu_vsew_o,
  input  elen_t       alu_res_i,
  // Result queue
  input  logic        rq_full_i,
  output logic        push_o,
  output result_t     push_data_o
);

  alu_insn_t insn;
  elen_t     scalar_rep;
  logic      use_a;
  logic      use_mask;
  logic      operands_ok;
  logic      fire;
  vlen_t     epw;
  vlen_t     elem_cnt;
  strb_t     be_cnt;

  // Word index inside the destination register
  logic [word_idx_width-1:0] word_cnt_q;

  assign insn = issue_i.insn;

  //////////////////////////////////////////////////////////////////////
  // Operands
  //////////////////////////////////////////////////////////////////////

  // Scalar copied into every lane of the element width
  always_comb begin
    case (insn.vsew)
      ew8:     scalar_rep = {8{insn.scalar[7:0]}};
      ew16:    scalar_rep = {4{insn.scalar[15:0]}};
      ew32:    scalar_rep = {2{insn.scalar[31:0]}};
      default: scalar_rep = insn.scalar;
    endcase
  end

  // op_b is always a vector stream
  assign use_a    = !insn.use_scalar;
  assign use_mask = !insn.vm;

  assign operands_ok = (op_a_valid_i || !use_a) && op_b_valid_i &&
                       (mask_valid_i || !use_mask);

  // Stall while the result queue holds two words
  assign fire = issue_i.valid && !rq_full_i && operands_ok;

  // Readies only for the streams in use, only in the issue cycle
  assign op_a_ready_o = fire && use_a;
  assign op_b_ready_o = fire;
  assign mask_ready_o = fire && use_mask;

  assign alu_a_o    = insn.use_scalar ? scalar_rep : op_a_i;
  assign alu_b_o    = op_b_i;
  assign alu_op_o   = insn.op;
  assign alu_vsew_o = insn.vsew;

  //////////////////////////////////////////////////////////////////////
  // Element count and byte enables
  //////////////////////////////////////////////////////////////////////

  // Full word unless this is a short last word
  assign epw      = vlen_t'(strb_width >> insn.vsew);
  assign elem_cnt = (epw < issue_i.remaining) ? epw : issue_i.remaining;

  // Byte b belongs to element b >> vsew
  always_comb begin
    for (int b = 0; b < strb_width; b++) begin
      be_cnt[b] = ((vlen_t'(b) >> insn.vsew) < elem_cnt);
    end
  end

  assign issue_last_o  = fire && (elem_cnt == issue_i.remaining);
  assign elem_issued_o = fire ? elem_cnt : '0;

  //////////////////////////////////////////////////////////////////////
  // Result push
  //////////////////////////////////////////////////////////////////////

  // Counter equals (vl - remaining) >> (3 - vsew)
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      word_cnt_q <= '0;
    end else if (fire) begin
      word_cnt_q <= issue_last_o ? '0 : word_cnt_q + 1'b1;
    end
  end

  assign push_o            = fire;
  assign push_data_o.id    = insn.id;
  assign push_data_o.addr  = vaddr_t'(insn.vd) * vaddr_t'(vreg_words) + vaddr_t'(word_cnt_q);
  assign push_data_o.wdata = alu_res_i;
  // Inactive elements keep their bytes disabled
  assign push_data_o.be    = be_cnt & (insn.vm ? {strb_width{1'b1}} : mask_i);

endmodule

`default_nettype wire

// File: valu/valu_insn_queue.sv
// Instruction queue of the vector ALU; tracks accept, issue and commit phases and pulses done bits
`timescale 1ns/1ps
`default_nettype none

module valu_insn_queue import valu_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,
  // New instructions
  input  alu_insn_t           insn_i,
  input  logic                insn_valid_i,
  output logic                insn_ready_o,
  // Issue stage
  output issue_info_t         issue_o,
  input  logic                issue_last_i,
  input  vlen_t               elem_issued_i,
  // Register-file grant of one result word
  input  logic                commit_i,
  output logic [nr_vinsn-1:0] done_o
);

  // Instruction storage, written only on accept
  alu_insn_t insn_q [insn_queue_depth];

  logic [iq_idx_width-1:0] accept_pnt_d, accept_pnt_q;
  logic [iq_idx_width-1:0] issue_pnt_d, issue_pnt_q;
  logic [iq_idx_width-1:0] commit_pnt_d, commit_pnt_q;
  // Instructions still waiting to issue / to commit
  logic [iq_idx_width:0]   issue_cnt_d, issue_cnt_q;
  logic [iq_idx_width:0]   commit_cnt_d, commit_cnt_q;
  // Remaining elements of the head instruction in each phase
  vlen_t                   issue_rem_d, issue_rem_q;
  vlen_t                   commit_rem_d, commit_rem_q;

  logic      accept;
  alu_insn_t commit_insn;
  vlen_t     commit_epw;

  // Full once every slot waits for commit
  assign insn_ready_o = (commit_cnt_q != (iq_idx_width+1)'(insn_queue_depth));
  assign accept       = insn_valid_i && insn_ready_o;

  assign issue_o.valid     = (issue_cnt_q != '0);
  assign issue_o.insn      = insn_q[issue_pnt_q];
  assign issue_o.remaining = issue_rem_q;

  // Elements carried by each committed word
  assign commit_insn = insn_q[commit_pnt_q];
  assign commit_epw  = vlen_t'(strb_width >> commit_insn.vsew);

  always_comb begin
    accept_pnt_d = accept_pnt_q;
    issue_pnt_d  = issue_pnt_q;
    commit_pnt_d = commit_pnt_q;
    issue_cnt_d  = issue_cnt_q;
    commit_cnt_d = commit_cnt_q;
    issue_rem_d  = issue_rem_q;
    commit_rem_d = commit_rem_q;
    done_o       = '0;

    // Issue phase, a nonzero count means a word left this cycle
    if (elem_issued_i != '0) begin
      issue_rem_d = issue_rem_q - elem_issued_i;
    end
    if (issue_last_i) begin
      issue_pnt_d = issue_pnt_q + 1'b1;
      issue_cnt_d = issue_cnt_q - 1'b1;
      // Next queued instruction starts from its full vl
      if (issue_cnt_d != '0) begin
        issue_rem_d = insn_q[issue_pnt_d].vl;
      end
    end

    // Commit phase, last word may be partial
    if (commit_i) begin
      if (commit_rem_q <= commit_epw) begin
        done_o[commit_insn.id] = 1'b1;
        commit_pnt_d = commit_pnt_q + 1'b1;
        commit_cnt_d = commit_cnt_q - 1'b1;
        if (commit_cnt_d != '0) begin
          commit_rem_d = insn_q[commit_pnt_d].vl;
        end
      end else begin
        commit_rem_d = commit_rem_q - commit_epw;
      end
    end

    // Accept phase; an empty phase takes its counter from the new instruction
    if (accept) begin
      if (issue_cnt_d == '0) begin
        issue_rem_d = insn_i.vl;
      end
      if (commit_cnt_d == '0) begin
        commit_rem_d = insn_i.vl;
      end
      accept_pnt_d = accept_pnt_q + 1'b1;
      issue_cnt_d  = issue_cnt_d + 1'b1;
      commit_cnt_d = commit_cnt_d + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q <= '0;
      issue_pnt_q  <= '0;
      commit_pnt_q <= '0;
      issue_cnt_q  <= '0;
      commit_cnt_q <= '0;
      issue_rem_q  <= '0;
      commit_rem_q <= '0;
    end else begin
      accept_pnt_q <= accept_pnt_d;
      issue_pnt_q  <= issue_pnt_d;
      commit_pnt_q <= commit_pnt_d;
      issue_cnt_q  <= issue_cnt_d;
      commit_cnt_q <= commit_cnt_d;
      issue_rem_q  <= issue_rem_d;
      commit_rem_q <= commit_rem_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      insn_q[accept_pnt_q] <= insn_i;
    end
  end

endmodule

`default_nettype wire

// File: verilog/simd_alu.sv
// Combinational SIMD integer datapath applying one op to every lane of a 64-bit word
`timescale 1ns/1ps
`default_nettype none

module simd_alu import valu_pkg::*; (
  input  elen_t   a_i,
  input  elen_t   b_i,
  input  alu_op_e op_i,
  input  vsew_e   vsew_i,
  output elen_t   result_o
);

  simd_word_u a_u;
  simd_word_u b_u;
  simd_word_u res_u;

  assign a_u = a_i;
  assign b_u = b_i;

  // One lane of width w; a and b arrive sign-extended to 64 bits
  // Sign extension keeps unsigned order, so minu compares directly
  function automatic elen_t lane_op(alu_op_e op, elen_t a, elen_t b, logic [6:0] w);
    elen_t      lane_mask;
    logic [5:0] sh;
    lane_mask = (w == 7'd64) ? '1 : ((elen_t'(1) << w) - 1'b1);
    // Shift amount is log2(w) bits of b
    sh = b[5:0] & 6'(w - 7'd1);
    case (op)
      op_add:  lane_op = a + b;
      op_sub:  lane_op = a - b;
      op_rsub: lane_op = b - a;
      op_and:  lane_op = a & b;
      op_or:   lane_op = a | b;
      op_xor:  lane_op = a ^ b;
      op_minu: lane_op = (a < b) ? a : b;
      op_max:  lane_op = ($signed(a) > $signed(b)) ? a : b;
      op_sll:  lane_op = a << sh;
      // Logical shift must not pull in the extension bits
      op_srl:  lane_op = (a & lane_mask) >> sh;
      op_sra:  lane_op = elen_t'($signed(a) >>> sh);
      default: lane_op = '0;
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Lane split per element width
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    res_u.d = '0;
    case (vsew_i)
      ew8: begin
        for (int i = 0; i < strb_width; i++) begin
          res_u.b[i] = 8'(lane_op(op_i, 64'($signed(a_u.b[i])),
                                  64'($signed(b_u.b[i])), 7'd8));
        end
      end
      ew16: begin
        for (int i = 0; i < strb_width / 2; i++) begin
          res_u.h[i] = 16'(lane_op(op_i, 64'($signed(a_u.h[i])),
                                   64'($signed(b_u.h[i])), 7'd16));
        end
      end
      ew32: begin
        for (int i = 0; i < strb_width / 4; i++) begin
          res_u.w[i] = 32'(lane_op(op_i, 64'($signed(a_u.w[i])),
                                   64'($signed(b_u.w[i])), 7'd32));
        end
      end
      ew64: begin
        // Whole word is a single lane
        res_u.d = lane_op(op_i, a_u.d, b_u.d, 7'd64);
      end
      default: begin
        res_u.d = '0;
      end
    endcase
  end

  assign result_o = res_u.d;

endmodule

`default_nettype wire

// File: common/valu_pkg.sv
// Shared widths, opcodes, element-width encoding and transfer types of the vector ALU lane
`default_nettype none

package valu_pkg;

  //////////////////////////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////////////////////////

  // Data word and its byte strobes
  localparam int unsigned elen_width = 64;
  localparam int unsigned strb_width = elen_width / 8;

  // In-flight instructions and buffered result words
  localparam int unsigned insn_queue_depth   = 4;
  localparam int unsigned result_queue_depth = 2;

  // Instruction IDs, one done bit each
  localparam int unsigned nr_vinsn = 8;

  // Words of one vector register held by this lane
  localparam int unsigned vreg_words = 16;

  // Pointer widths, depths are powers of two so pointers wrap on their own
  localparam int unsigned iq_idx_width   = $clog2(insn_queue_depth);
  localparam int unsigned rq_idx_width   = $clog2(result_queue_depth);
  localparam int unsigned word_idx_width = $clog2(vreg_words);

  //////////////////////////////////////////////////////////////////////
  // Scalar types and encodings
  //////////////////////////////////////////////////////////////////////

  typedef logic [elen_width-1:0] elen_t;
  typedef logic [strb_width-1:0] strb_t;
  typedef logic [7:0]            vlen_t;
  typedef logic [2:0]            vid_t;
  typedef logic [8:0]            vaddr_t;

  // Element width, the value is log2 of the bytes per element
  typedef enum logic [1:0] {
    ew8  = 2'd0,
    ew16 = 2'd1,
    ew32 = 2'd2,
    ew64 = 2'd3
  } vsew_e;

  // Element-wise integer ops
  typedef enum logic [3:0] {
    op_add, op_sub, op_rsub,
    op_and, op_or, op_xor,
    op_minu, op_max,
    op_sll, op_srl, op_sra
  } alu_op_e;

  // One data word split into lanes of each element width
  typedef union packed {
    logic [7:0][7:0]  b;
    logic [3:0][15:0] h;
    logic [1:0][31:0] w;
    logic [63:0]      d;
  } simd_word_u;

  //////////////////////////////////////////////////////////////////////
  // Transfer structs
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    vid_t    id;
    alu_op_e op;
    vsew_e   vsew;
    vlen_t   vl;
    logic [4:0] vd;
    // Set when every element is active
    logic    vm;
    // Operand a comes from the scalar instead of the op_a stream
    logic    use_scalar;
    elen_t   scalar;
  } alu_insn_t;

  typedef struct packed {
    vid_t   id;
    vaddr_t addr;
    elen_t  wdata;
    strb_t  be;
  } result_t;

  // Head of the issue phase as seen by the issue stage
  typedef struct packed {
    logic      valid;
    alu_insn_t insn;
    vlen_t     remaining;
  } issue_info_t;

endpackage

`default_nettype wire
